//--- hdl/bpPipePkg.sv
//////////////////////////////
// pipeline message types
// decode pair, execute resolve, prediction
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

package bpPipePkg;

    // decoded instruction pair, slot 1 is the lower word
    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] pc;        // pair address
        bpTablePkg::brKind_t       kind1;
        bpTablePkg::brKind_t       kind2;
        logic [`BP_ADDR_WIDTH-1:0] target1;
        logic [`BP_ADDR_WIDTH-1:0] target2;
    } decodePair_t;

    // resolved branch from execute
    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] pc;        // bit 2 picks the slot
        bpTablePkg::brKind_t       kind;
        logic                      taken;
    } resolve_t;

    // prediction handed back to fetch
    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] nextPC;
        logic                      branch;    // a slot is taken
        logic                      reason;    // 0 lower, 1 upper
        logic                      known1;    // raw hit, lower
        logic                      known2;    // raw hit, upper
        logic [`BP_ADDR_WIDTH-1:0] target1;
        logic [`BP_ADDR_WIDTH-1:0] target2;
    } prediction_t;

endpackage

`default_nettype wire

//--- hdl/bpTablePkg.sv
//////////////////////////////
// table storage types
// branch kind, fact entry, counter pair
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

package bpTablePkg;

    // instruction kind, stored per slot
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,   // no control transfer
        KIND_COND = 2'd1,   // conditional branch
        KIND_JUMP = 2'd2,   // jump or call
        KIND_RET  = 2'd3    // return, target from stack
    } brKind_t;

    // one fact table entry, covers an aligned pair
    typedef struct packed {
        logic                      valid;
        logic [`BP_TAG_WIDTH-1:0]  tag;      // pc bits above index
        brKind_t                   kind1;    // lower slot
        brKind_t                   kind2;    // upper slot
        logic [`BP_ADDR_WIDTH-1:0] target1;
        logic [`BP_ADDR_WIDTH-1:0] target2;
    } factEntry_t;

    // 2-bit saturating counters, high bit = taken
    typedef struct packed {
        logic [1:0] ctr1;   // lower slot
        logic [1:0] ctr2;   // upper slot
    } ctrPair_t;

endpackage

`default_nettype wire

//--- hdl/bp_consts.svh
//////////////////////////////
// branch predictor constants
// address split, table and return stack sizes
//////////////////////////////
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// fetch and target address bits
`define BP_ADDR_WIDTH 32

// table index bits, 16 entries per table
`define BP_HASH_DEPTH 4

// address bits above the index, bits 2..0 are slot and byte offset
`define BP_TAG_WIDTH (`BP_ADDR_WIDTH - 3 - `BP_HASH_DEPTH)

// return address stack entries, power of two
`define BP_RAS_DEPTH 4

`endif

//--- hdl/branchUnit.sv
//////////////////////////////
// branchUnit top level
// fact table, past table, predictor
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module branchUnit (
    input  logic                          clk,
    input  logic                          rstN,

    input  logic                          ifVld,     // fetch
    input  logic [`BP_ADDR_WIDTH-1:0]     ifPC,

    input  logic                          idVld,     // decode
    input  bpPipePkg::decodePair_t        idPair,

    input  logic                          exVld,     // execute
    input  bpPipePkg::resolve_t           exRes,
    input  logic                          exWrong,

    input  logic                          push,      // call return address
    input  logic [`BP_ADDR_WIDTH-1:0]     pushAddr,

    output bpPipePkg::prediction_t        pdOut
);

    bpTablePkg::factEntry_t ifFact;
    logic                   ifHit1;
    logic                   ifHit2;
    bpTablePkg::ctrPair_t   ifCtr;

    // targets and kinds
    factTable fact (
        .clk     (clk),
        .rstN    (rstN),
        .idVld   (idVld),
        .idPair  (idPair),
        .ifPC    (ifPC),
        .ifFact  (ifFact),
        .ifHit1  (ifHit1),
        .ifHit2  (ifHit2)
    );

    // direction history
    pastTable past (
        .clk     (clk),
        .rstN    (rstN),
        .idVld   (idVld),
        .idPair  (idPair),
        .exVld   (exVld),
        .exRes   (exRes),
        .ifPC    (ifPC),
        .ifCtr   (ifCtr)
    );

    predictUnit predict (
        .clk      (clk),
        .rstN     (rstN),
        .ifVld    (ifVld),
        .ifPC     (ifPC),
        .ifFact   (ifFact),
        .ifHit1   (ifHit1),
        .ifHit2   (ifHit2),
        .ifCtr    (ifCtr),
        .exWrong  (exWrong),
        .push     (push),
        .pushAddr (pushAddr),
        .pdOut    (pdOut)
    );

endmodule

`default_nettype wire

//--- hdl/factTable.sv
//////////////////////////////
// factTable
// hashed target table, decode write,
// zero latency lookup by fetch pc
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module factTable (
    input  logic                          clk,
    input  logic                          rstN,

    input  logic                          idVld,   // decode write strobe
    input  bpPipePkg::decodePair_t        idPair,  // pair to record

    input  logic [`BP_ADDR_WIDTH-1:0]     ifPC,    // fetch address
    output bpTablePkg::factEntry_t        ifFact,  // entry at ifPC index
    output logic                          ifHit1,  // lower slot known
    output logic                          ifHit2   // upper slot known
);

    localparam int tableDepth = 1 << `BP_HASH_DEPTH;

    bpTablePkg::factEntry_t          factMem [tableDepth];

    logic [`BP_HASH_DEPTH-1:0]       idIdx;
    logic [`BP_TAG_WIDTH-1:0]        idTag;
    bpTablePkg::factEntry_t          idEntry;   // entry built from decode

    logic [`BP_HASH_DEPTH-1:0]       ifIdx;
    logic [`BP_TAG_WIDTH-1:0]        ifTag;
    logic                            tagHit;

    //////////////////////////////
    // decode side
    //////////////////////////////
    assign idIdx = idPair.pc[3 +: `BP_HASH_DEPTH];
    assign idTag = idPair.pc[`BP_ADDR_WIDTH-1 -: `BP_TAG_WIDTH];

    always_comb begin
        idEntry.valid   = 1'b1;
        idEntry.tag     = idTag;
        idEntry.kind1   = idPair.kind1;
        idEntry.kind2   = idPair.kind2;
        idEntry.target1 = idPair.target1;
        idEntry.target2 = idPair.target2;
    end

    // whole entry replaced on write, tag included
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < tableDepth; i++) begin
                factMem[i].valid <= 1'b0;   // payload kept, only valid cleared
            end
        end else if (idVld) begin
            factMem[idIdx] <= idEntry;
        end
    end

    //////////////////////////////
    // fetch side lookup
    //////////////////////////////
    assign ifIdx  = ifPC[3 +: `BP_HASH_DEPTH];
    assign ifTag  = ifPC[`BP_ADDR_WIDTH-1 -: `BP_TAG_WIDTH];
    assign ifFact = factMem[ifIdx];

    assign tagHit = ifFact.valid && (ifFact.tag == ifTag);

    // slot known only if something was decoded there
    assign ifHit1 = tagHit && (ifFact.kind1 != bpTablePkg::KIND_NONE);
    assign ifHit2 = tagHit && (ifFact.kind2 != bpTablePkg::KIND_NONE);

endmodule

`default_nettype wire

//--- hdl/pastTable.sv
//////////////////////////////
// pastTable
// per slot 2-bit counters, seeded by decode,
// trained by execute on conditionals
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module pastTable (
    input  logic                          clk,
    input  logic                          rstN,

    input  logic                          idVld,   // decode write strobe
    input  bpPipePkg::decodePair_t        idPair,

    input  logic                          exVld,   // execute resolve strobe
    input  bpPipePkg::resolve_t           exRes,

    input  logic [`BP_ADDR_WIDTH-1:0]     ifPC,
    output bpTablePkg::ctrPair_t          ifCtr    // counters at ifPC index
);

    localparam int tableDepth = 1 << `BP_HASH_DEPTH;
    localparam bpTablePkg::ctrPair_t ctrReset = '{ctr1: 2'b01, ctr2: 2'b01};

    bpTablePkg::ctrPair_t            ctrMem [tableDepth];

    logic [`BP_HASH_DEPTH-1:0]       idIdx;
    logic [`BP_HASH_DEPTH-1:0]       exIdx;
    logic [`BP_ADDR_WIDTH-1:0]       lowPC;     // lower slot address
    logic [`BP_ADDR_WIDTH-1:0]       upPC;      // upper slot address
    bpTablePkg::ctrPair_t            idInit;
    logic                            exTrain;

    // backward target starts weakly taken, anything else weakly not taken
    function automatic logic [1:0] seedCtr(
        input logic [`BP_ADDR_WIDTH-1:0] slotPC,
        input logic [`BP_ADDR_WIDTH-1:0] target
    );
        if (target[`BP_ADDR_WIDTH-1:2] < slotPC[`BP_ADDR_WIDTH-1:2]) begin
            return 2'b10;
        end
        return 2'b01;
    endfunction

    // saturating step, 00 and 11 are the rails
    function automatic logic [1:0] stepCtr(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    //////////////////////////////
    // decode seed
    //////////////////////////////
    assign idIdx = idPair.pc[3 +: `BP_HASH_DEPTH];
    assign lowPC = {idPair.pc[`BP_ADDR_WIDTH-1:3], 3'b000};
    assign upPC  = {idPair.pc[`BP_ADDR_WIDTH-1:3], 3'b100};

    assign idInit.ctr1 = seedCtr(lowPC, idPair.target1);
    assign idInit.ctr2 = seedCtr(upPC, idPair.target2);

    // execute training, conditionals only
    assign exIdx   = exRes.pc[3 +: `BP_HASH_DEPTH];
    assign exTrain = exVld && (exRes.kind == bpTablePkg::KIND_COND);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < tableDepth; i++) begin
                ctrMem[i] <= ctrReset;
            end
        end else begin
            if (exTrain) begin
                if (exRes.pc[2]) begin
                    ctrMem[exIdx].ctr2 <= stepCtr(ctrMem[exIdx].ctr2, exRes.taken);
                end else begin
                    ctrMem[exIdx].ctr1 <= stepCtr(ctrMem[exIdx].ctr1, exRes.taken);
                end
            end
            // decode goes last so it wins on a shared index
            if (idVld) begin
                ctrMem[idIdx] <= idInit;
            end
        end
    end

    // no tag here, factTable decides the hit
    assign ifCtr = ctrMem[ifPC[3 +: `BP_HASH_DEPTH]];

endmodule

`default_nettype wire

//--- hdl/predictUnit.sv
//////////////////////////////
// predictUnit
// slot pick, next pc choice,
// return address stack
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module predictUnit (
    input  logic                          clk,
    input  logic                          rstN,

    input  logic                          ifVld,     // fetch active, allows pop
    input  logic [`BP_ADDR_WIDTH-1:0]     ifPC,
    input  bpTablePkg::factEntry_t        ifFact,
    input  logic                          ifHit1,
    input  logic                          ifHit2,
    input  bpTablePkg::ctrPair_t          ifCtr,

    input  logic                          exWrong,   // mispredict, flush stack
    input  logic                          push,      // call seen
    input  logic [`BP_ADDR_WIDTH-1:0]     pushAddr,  // its return address

    output bpPipePkg::prediction_t        pdOut
);

    localparam int rasDepth = `BP_RAS_DEPTH;
    localparam int ptrWidth = $clog2(rasDepth);
    localparam int cntWidth = $clog2(rasDepth + 1);

    logic [`BP_ADDR_WIDTH-1:0] rasMem [rasDepth];
    logic [ptrWidth-1:0]       rasTop;      // points at newest entry
    logic [ptrWidth-1:0]       nextTop;
    logic [ptrWidth-1:0]       prevTop;
    logic [cntWidth-1:0]       rasCnt;      // saturates at depth
    logic                      rasEmpty;
    logic [`BP_ADDR_WIDTH-1:0] rasData;

    logic                      take1;
    logic                      take2;
    logic                      pop;
    logic [`BP_ADDR_WIDTH-1:0] seqPC;       // fall through, next pair

    function automatic logic slotTaken(
        input logic                hit,
        input bpTablePkg::brKind_t kind,
        input logic [1:0]          ctr,
        input logic                empty
    );
        case (kind)
            bpTablePkg::KIND_JUMP: return hit;
            bpTablePkg::KIND_COND: return hit && ctr[1];
            bpTablePkg::KIND_RET:  return hit && !empty;
            default:               return 1'b0;
        endcase
    endfunction

    //////////////////////////////
    // slot selection
    //////////////////////////////
    // lower slot skipped when fetch enters at the upper word
    assign take1 = !ifPC[2] && slotTaken(ifHit1, ifFact.kind1, ifCtr.ctr1, rasEmpty);
    assign take2 = slotTaken(ifHit2, ifFact.kind2, ifCtr.ctr2, rasEmpty);

    assign seqPC = {ifPC[`BP_ADDR_WIDTH-1:3] + 1'b1, 3'b000};

    always_comb begin
        pdOut.branch  = take1 || take2;
        pdOut.reason  = !take1 && take2;            // upper only when lower not taken
        pdOut.known1  = ifHit1;
        pdOut.known2  = ifHit2;
        pdOut.target1 = ifFact.target1;
        pdOut.target2 = ifFact.target2;
        if (take1) begin
            pdOut.nextPC = (ifFact.kind1 == bpTablePkg::KIND_RET) ? rasData : ifFact.target1;
        end else if (take2) begin
            pdOut.nextPC = (ifFact.kind2 == bpTablePkg::KIND_RET) ? rasData : ifFact.target2;
        end else begin
            pdOut.nextPC = seqPC;
        end
    end

    // pop only for the chosen return on a real fetch
    assign pop = ifVld && ((take1 && ifFact.kind1 == bpTablePkg::KIND_RET) ||
                           (!take1 && take2 && ifFact.kind2 == bpTablePkg::KIND_RET));

    //////////////////////////////
    // return address stack
    //////////////////////////////
    assign rasEmpty = (rasCnt == '0);
    assign rasData  = rasMem[rasTop];
    assign nextTop  = rasTop + 1'b1;   // wraps, overwrites oldest
    assign prevTop  = rasTop - 1'b1;

    // push with pop rewrites the top in place
    always_ff @(posedge clk) begin
        if (push && !exWrong) begin
            rasMem[pop ? rasTop : nextTop] <= pushAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rasTop <= '0;
            rasCnt <= '0;
        end else if (exWrong) begin
            rasTop <= '0;                // flush beats push and pop
            rasCnt <= '0;
        end else if (push && !pop) begin
            rasTop <= nextTop;
            if (rasCnt != cntWidth'(rasDepth)) begin
                rasCnt <= rasCnt + 1'b1;
            end
        end else if (pop && !push) begin
            rasTop <= prevTop;
            rasCnt <= rasCnt - 1'b1;     // pop implies not empty
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbBranchUnit -f sources.f

# assertion errors are counted by the testbench, so the run must not stop at the first
out=$(./obj_dir/VtbBranchUnit +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+hdl
hdl/bpTablePkg.sv
hdl/bpPipePkg.sv
hdl/factTable.sv
hdl/pastTable.sv
hdl/predictUnit.sv
hdl/branchUnit.sv
verif/branchUnit_props.sv
verif/tbBranchUnit.sv

//--- verif/branchUnit_props.sv
//////////////////////////////
// branchUnitProps
// reset state and prediction consistency,
// bound to branchUnit
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module branchUnitProps (
    input wire logic                      clk,
    input wire logic                      rstN,
    input wire logic [`BP_ADDR_WIDTH-1:0] ifPC,
    input wire bpPipePkg::prediction_t    pdOut
);

    int   assertFails = 0;   // read by the testbench at the end
    logic afterRst = 1'b0;   // reset was applied at the previous edge

    always_ff @(posedge clk) afterRst <= !rstN;

    // tables and stack cleared, nothing known
    resetQuiet: assert property (@(posedge clk)
        afterRst |-> (!pdOut.branch && !pdOut.known1 && !pdOut.known2))
        else begin
            $error("prediction active during or right after reset");
            assertFails++;
        end

    resonWithBranch: assert property (@(posedge clk) disable iff (!rstN)
        pdOut.reason |-> pdOut.branch)
        else begin
            $error("reason set without a branch");
            assertFails++;
        end

    // fall through is the next aligned pair
    seqNext: assert property (@(posedge clk) disable iff (!rstN)
        !pdOut.branch |-> (pdOut.nextPC == {ifPC[`BP_ADDR_WIDTH-1:3], 3'b000} + 32'd8))
        else begin
            $error("no branch but next pc is not the next pair");
            assertFails++;
        end

endmodule

bind branchUnit branchUnitProps props (.clk(clk), .rstN(rstN), .ifPC(ifPC), .pdOut(pdOut));

`default_nettype wire

//--- verif/tbBranchUnit.sv
//////////////////////////////
// tbBranchUnit
// clock, reset, stimulus, reference model
// of tables and return stack, verdict
//////////////////////////////
`default_nettype none

`include "bp_consts.svh"

module tbBranchUnit;

    logic clk = 1'b0;
    logic rstN, ifVld, idVld, exVld, exWrong, push;
    logic [`BP_ADDR_WIDTH-1:0] ifPC, pushAddr;
    bpPipePkg::decodePair_t    idPair;
    bpPipePkg::resolve_t       exRes;
    bpPipePkg::prediction_t    pdOut;

    bpTablePkg::factEntry_t    mFact [16];   // model of factTable
    bpTablePkg::ctrPair_t      mCtr [16];    // model of pastTable
    logic [`BP_ADDR_WIDTH-1:0] rasQ [$];     // model stack, newest at back
    logic [31:0] rngState = 32'd80075;
    int errCnt = 0, passCnt = 0, failCnt = 0;

    branchUnit UUT (.clk(clk), .rstN(rstN), .ifVld(ifVld), .ifPC(ifPC), .idVld(idVld),
        .idPair(idPair), .exVld(exVld), .exRes(exRes), .exWrong(exWrong), .push(push),
        .pushAddr(pushAddr), .pdOut(pdOut));

    always #50 clk = ~clk;

    function automatic logic [31:0] randWord();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic hitOf(input logic [31:0] pc, input bpTablePkg::brKind_t kind);
        bpTablePkg::factEntry_t e;
        e = mFact[pc[3 +: `BP_HASH_DEPTH]];
        return e.valid && e.tag == pc[31 -: `BP_TAG_WIDTH] && kind != bpTablePkg::KIND_NONE;
    endfunction

    function automatic logic takes(input bpTablePkg::brKind_t kind, input logic [1:0] ctr);
        if (kind == bpTablePkg::KIND_JUMP) return 1'b1;
        if (kind == bpTablePkg::KIND_COND) return ctr >= 2'd2;   // upper half taken
        if (kind == bpTablePkg::KIND_RET) return rasQ.size() > 0;
        return 1'b0;
    endfunction

    // 0 none, 1 lower, 2 upper
    function automatic int pickSlot(input logic [31:0] pc);
        bpTablePkg::factEntry_t e;
        bpTablePkg::ctrPair_t c;
        e = mFact[pc[3 +: `BP_HASH_DEPTH]];
        c = mCtr[pc[3 +: `BP_HASH_DEPTH]];
        if (!pc[2] && hitOf(pc, e.kind1) && takes(e.kind1, c.ctr1)) return 1;
        if (hitOf(pc, e.kind2) && takes(e.kind2, c.ctr2)) return 2;
        return 0;
    endfunction

    function automatic bpPipePkg::prediction_t expected(input logic [31:0] pc);
        bpPipePkg::prediction_t p;
        bpTablePkg::factEntry_t e;
        int slot;
        e = mFact[pc[3 +: `BP_HASH_DEPTH]];
        slot = pickSlot(pc);
        p.known1 = hitOf(pc, e.kind1);
        p.known2 = hitOf(pc, e.kind2);
        p.target1 = e.target1;
        p.target2 = e.target2;
        p.branch = slot != 0;
        p.reason = slot == 2;
        p.nextPC = (pc & ~32'h7) + 32'd8;
        if (slot == 1) p.nextPC = (e.kind1 == bpTablePkg::KIND_RET) ? rasQ[$] : e.target1;
        if (slot == 2) p.nextPC = (e.kind2 == bpTablePkg::KIND_RET) ? rasQ[$] : e.target2;
        return p;
    endfunction

    function automatic logic [1:0] bump(input logic [1:0] ctr, input logic taken);
        int v;
        v = int'(ctr) + (taken ? 1 : -1);
        return (v < 0) ? 2'd0 : (v > 3) ? 2'd3 : v[1:0];
    endfunction

    // state change at one rising edge, inputs as driven
    task automatic modelUpdate();
        int slot;
        logic popNow;
        logic [`BP_HASH_DEPTH-1:0] i;
        logic [31:0] base;
        if (!rstN) begin
            for (int k = 0; k < 16; k++) begin
                mFact[k].valid = 1'b0;
                mCtr[k] = 4'b0101;
            end
            rasQ.delete();
            return;
        end
        slot = pickSlot(ifPC);
        i = ifPC[3 +: `BP_HASH_DEPTH];
        popNow = ifVld && ((slot == 1 && mFact[i].kind1 == bpTablePkg::KIND_RET) ||
                           (slot == 2 && mFact[i].kind2 == bpTablePkg::KIND_RET));
        if (exVld && exRes.kind == bpTablePkg::KIND_COND) begin
            i = exRes.pc[3 +: `BP_HASH_DEPTH];
            if (exRes.pc[2]) mCtr[i].ctr2 = bump(mCtr[i].ctr2, exRes.taken);
            else mCtr[i].ctr1 = bump(mCtr[i].ctr1, exRes.taken);
        end
        if (idVld) begin   // after training, decode wins
            i = idPair.pc[3 +: `BP_HASH_DEPTH];
            base = idPair.pc & ~32'h7;
            mFact[i].valid = 1'b1;
            mFact[i].tag = idPair.pc[31 -: `BP_TAG_WIDTH];
            mFact[i].kind1 = idPair.kind1;
            mFact[i].kind2 = idPair.kind2;
            mFact[i].target1 = idPair.target1;
            mFact[i].target2 = idPair.target2;
            mCtr[i].ctr1 = (idPair.target1 >> 2) < (base >> 2) ? 2'b10 : 2'b01;
            mCtr[i].ctr2 = (idPair.target2 >> 2) < ((base + 4) >> 2) ? 2'b10 : 2'b01;
        end
        if (exWrong) rasQ.delete();
        else if (push && popNow) rasQ[rasQ.size()-1] = pushAddr;   // top replaced
        else if (push) begin
            rasQ.push_back(pushAddr);
            if (rasQ.size() > `BP_RAS_DEPTH) void'(rasQ.pop_front());   // oldest lost
        end else if (popNow) void'(rasQ.pop_back());
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    // one cycle, returns at the falling edge with strobes low
    task automatic tick();
        @(posedge clk);
        modelUpdate();
        @(negedge clk);
        {ifVld, idVld, exVld, exWrong, push} = '0;
    endtask

    task automatic cmp(input string field, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got) else begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, field, exp, got);
            errCnt++;
        end
    endtask

    // fetch at the falling edge, compare, then clock it
    task automatic fetch(input logic [31:0] pc, input logic vld);
        bpPipePkg::prediction_t exp;
        int n;
        ifPC = pc;
        ifVld = vld;
        #10;   // combinational lookup settles
        n = 0;
        while ($isunknown({pdOut.nextPC, pdOut.branch, pdOut.reason, pdOut.known1,
                           pdOut.known2})) begin
            if (n == 50) begin
                $display("timeout, prediction stayed unknown for 50 cycles");
                $display("TB FAILED");
                $finish;
            end
            n++;
            tick();
            ifVld = vld;
            #10;
        end
        exp = expected(pc);
        cmp("pdOut.nextPC", exp.nextPC, pdOut.nextPC);
        cmp("pdOut.branch", 32'(exp.branch), 32'(pdOut.branch));
        cmp("pdOut.reason", 32'(exp.reason), 32'(pdOut.reason));
        cmp("pdOut.known1", 32'(exp.known1), 32'(pdOut.known1));
        cmp("pdOut.known2", 32'(exp.known2), 32'(pdOut.known2));
        if (exp.known1) cmp("pdOut.target1", exp.target1, pdOut.target1);
        if (exp.known2) cmp("pdOut.target2", exp.target2, pdOut.target2);
        tick();
    endtask

    task automatic decode(input logic [31:0] pc, input bpTablePkg::brKind_t k1,
                          input bpTablePkg::brKind_t k2, input logic [31:0] t1, t2);
        idPair = '{pc: pc, kind1: k1, kind2: k2, target1: t1, target2: t2};
        idVld = 1'b1;
        tick();
    endtask

    task automatic resolve(input logic [31:0] pc, input bpTablePkg::brKind_t k, input logic t);
        exRes = '{pc: pc, kind: k, taken: t};
        exVld = 1'b1;
        tick();
    endtask

    task automatic pushRet(input logic [31:0] addr);
        pushAddr = addr;
        push = 1'b1;
        tick();
    endtask

    task automatic endTest(input string name);
        if (errCnt == 0) passCnt++;
        else failCnt++;
        $display("test %s: %0d errors", name, errCnt);
        errCnt = 0;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    initial begin
        logic [31:0] p;
        {rstN, ifVld, idVld, exVld, exWrong, push} = '0;
        ifPC = '0;
        pushAddr = '0;
        idPair = '0;
        exRes = '0;
        for (int k = 0; k < 5; k++) tick();
        rstN = 1'b1;

        for (int k = 0; k < 8; k++) fetch(randWord(), 1'b1);
        endTest("reset state");

        p = randWord() & ~32'h7;
        decode(p, bpTablePkg::KIND_NONE, bpTablePkg::KIND_JUMP, randWord(), randWord());
        fetch(p, 1'b1);
        fetch(p | 32'h4, 1'b1);
        fetch(p ^ 32'h0010_0000, 1'b1);   // same index, other tag
        endTest("upper jump");

        p = (randWord() & 32'h0FFF_FFF8) | 32'h1000_0000;
        decode(p, bpTablePkg::KIND_COND, bpTablePkg::KIND_COND, p - 64, p + 100);
        fetch(p, 1'b1);                   // backward taken, forward not
        for (int k = 0; k < 2; k++) resolve(p, bpTablePkg::KIND_COND, 1'b0);
        fetch(p, 1'b1);
        for (int k = 0; k < 2; k++) resolve(p, bpTablePkg::KIND_COND, 1'b0);
        resolve(p, bpTablePkg::KIND_COND, 1'b1);   // 00 then 01, still not taken
        fetch(p, 1'b1);
        for (int k = 0; k < 3; k++) resolve(p | 32'h4, bpTablePkg::KIND_JUMP, 1'b1);
        fetch(p | 32'h4, 1'b1);
        endTest("conditional counters");

        p = randWord() & ~32'h7;
        decode(p, bpTablePkg::KIND_JUMP, bpTablePkg::KIND_JUMP, randWord(), randWord());
        fetch(p, 1'b1);
        fetch(p | 32'h4, 1'b1);
        endTest("slot priority");

        p = randWord() & ~32'h7;
        for (int k = 0; k < 3; k++) pushRet(randWord());
        decode(p, bpTablePkg::KIND_RET, bpTablePkg::KIND_NONE, '0, '0);
        fetch(p, 1'b0);                   // no pop without ifVld
        for (int k = 0; k < 4; k++) fetch(p, 1'b1);
        for (int k = 0; k < 6; k++) pushRet(randWord());
        for (int k = 0; k < 5; k++) fetch(p, 1'b1);
        for (int k = 0; k < 2; k++) pushRet(randWord());
        exWrong = 1'b1;
        tick();
        fetch(p, 1'b1);
        endTest("return stack");

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passCnt, failCnt, UUT.props.assertFails);
        if (failCnt == 0 && UUT.props.assertFails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
